//--- spiker_pkg.sv
`default_nettype none
//--------------------------------------------------------------------
// Spiking core package
// Sizes, Q8.8 fixed-point neuron constants, activity monitor
// constants and the types shared by the silence-first detector
//--------------------------------------------------------------------

package spiker_pkg;

    //----------------------------------------------------------------
    // Sizes
    //----------------------------------------------------------------
    localparam int NUM_INPUTS    = 16;                        // Input layer
    localparam int NUM_RECURRENT = 32;                        // Recurrent layer
    localparam int NUM_SYNAPSES  = NUM_INPUTS * NUM_RECURRENT; // One per pair
    localparam int WEIGHT_BITS   = 8;
    localparam int DATA_WIDTH    = 16;                        // Currents and potentials
    localparam int FRAC_BITS     = 8;                         // Q8.8

    localparam int ADDR_BITS   = $clog2(NUM_SYNAPSES);
    localparam int COUNT_BITS  = $clog2(NUM_RECURRENT) + 1;   // 0 to 32 inclusive
    localparam int REFRAC_BITS = 3;                           // Holds up to 7
    localparam int STAT_BITS   = 32;                          // Kernel ABI word

    //----------------------------------------------------------------
    // Types
    //----------------------------------------------------------------
    typedef logic signed [WEIGHT_BITS-1:0] weight_t;
    typedef logic signed [DATA_WIDTH-1:0]  current_t;
    typedef logic [ADDR_BITS-1:0]          syn_addr_t;        // in * 32 + neuron
    typedef logic [NUM_INPUTS-1:0]         in_spikes_t;
    typedef logic [NUM_RECURRENT-1:0]      out_spikes_t;
    typedef logic [COUNT_BITS-1:0]         spike_count_t;
    typedef logic [STAT_BITS-1:0]          stat_t;

    // One current per recurrent neuron
    typedef current_t current_vec_t [NUM_RECURRENT];

    //----------------------------------------------------------------
    // Neuron constants
    //----------------------------------------------------------------
    localparam current_t V_THRESHOLD = current_t'(64 << FRAC_BITS);      // 0x4000
    localparam current_t V_RESET     = current_t'(0);
    localparam current_t V_REST      = current_t'(16 << FRAC_BITS);      // 0x1000
    localparam current_t LEAK_RATE   = current_t'(1 << (FRAC_BITS - 1)); // 0x0080
    localparam current_t V_MAX       = current_t'((1 << (DATA_WIDTH - 1)) - 1);

    localparam logic [REFRAC_BITS-1:0] REFRACTORY_CYCLES = REFRAC_BITS'(5);

    // Small inhibitory default so normal input stays silent
    localparam weight_t W_INIT = weight_t'(-8);

    //----------------------------------------------------------------
    // Monitor constants
    //----------------------------------------------------------------
    localparam spike_count_t ALERT_THRESHOLD = spike_count_t'(5);
    localparam int           WINDOW_CYCLES   = 256;
    localparam int           WINDOW_BITS     = $clog2(WINDOW_CYCLES);

endpackage : spiker_pkg

`default_nettype wire

//--- synapse_matrix.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// Synapse matrix
// Weight memory with a load and read-back port, plus the per-neuron
// synaptic current sum over the active inputs of each event
//--------------------------------------------------------------------

module synapse_matrix
    import spiker_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          enable,

    // Input event
    input  in_spikes_t   input_spikes,
    input  wire          input_valid,

    // Weight load and read-back
    input  wire          weight_we,
    input  syn_addr_t    weight_addr,
    input  weight_t      weight_wdata,
    output weight_t      weight_rdata,

    // To the neuron layer
    output current_vec_t currents,
    output logic         current_valid
);

    //----------------------------------------------------------------
    // Weight memory
    //----------------------------------------------------------------
    weight_t weights [NUM_SYNAPSES];   // W[i*32 + j], input i to neuron j

    // Power-up contents, every synapse inhibitory
    initial begin
        for (int k = 0; k < NUM_SYNAPSES; k++) begin
            weights[k] = W_INIT;
        end
    end

    // Synchronous write, independent of enable
    always @(posedge clk) begin
        if (weight_we) begin
            weights[weight_addr] <= weight_wdata;
        end
    end

    assign weight_rdata = weights[weight_addr];   // Combinational read-back

    //----------------------------------------------------------------
    // Current summation
    // I_j = sum over active inputs i of W[i][j], sign-extended
    //----------------------------------------------------------------
    current_vec_t next_currents;

    always_comb begin
        for (int j = 0; j < NUM_RECURRENT; j++) begin
            next_currents[j] = '0;
            for (int i = 0; i < NUM_INPUTS; i++) begin
                if (input_spikes[i]) begin
                    // Signed cast widens with the sign bit
                    next_currents[j] = next_currents[j]
                                     + current_t'(weights[i * NUM_RECURRENT + j]);
                end
            end
        end
    end

    // Payload register, loaded only on an accepted event
    always_ff @(posedge clk) begin
        if (enable && input_valid) begin
            currents <= next_currents;
        end
    end

    // One-cycle strobe per event, held while disabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_valid <= 1'b0;
        end else if (enable) begin
            current_valid <= input_valid;
        end
    end

endmodule : synapse_matrix

`default_nettype wire

//--- lif_layer.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// LIF neuron layer
// Leaky integrate-and-fire neurons with a refractory period, one
// spike vector per enabled cycle and its registered population count
//--------------------------------------------------------------------

module lif_layer
    import spiker_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          enable,

    // From the synapse matrix
    input  current_vec_t currents,
    input  wire          current_valid,

    // Spikes and their count
    output out_spikes_t  output_spikes,
    output spike_count_t spike_count
);

    localparam int EXT_BITS = DATA_WIDTH + 2;    // Room for sum and difference

    //----------------------------------------------------------------
    // Neuron state
    //----------------------------------------------------------------
    current_t               v_mem   [NUM_RECURRENT];  // Membrane potentials
    logic [REFRAC_BITS-1:0] ref_cnt [NUM_RECURRENT];  // Refractory counters

    current_t               v_next   [NUM_RECURRENT];
    logic [REFRAC_BITS-1:0] ref_next [NUM_RECURRENT];
    out_spikes_t            spk_next;
    spike_count_t           cnt_next;

    //----------------------------------------------------------------
    // Next-state logic for every neuron
    //----------------------------------------------------------------
    always_comb begin
        logic signed [EXT_BITS-1:0] v_sum;
        current_t                   v_clamp;

        cnt_next = '0;
        for (int j = 0; j < NUM_RECURRENT; j++) begin
            v_sum = EXT_BITS'(v_mem[j]) - EXT_BITS'(LEAK_RATE);
            if (current_valid) begin
                v_sum = v_sum + EXT_BITS'(currents[j]);   // Integrate event
            end

            // Clamp to zero .. largest positive
            if (v_sum < 0) begin
                v_clamp = '0;
            end else if (v_sum > EXT_BITS'(V_MAX)) begin
                v_clamp = V_MAX;
            end else begin
                v_clamp = current_t'(v_sum);
            end

            if (ref_cnt[j] != '0) begin
                // Refractory, pinned at reset level
                v_next[j]   = V_RESET;
                ref_next[j] = ref_cnt[j] - 1'b1;
                spk_next[j] = 1'b0;
            end else if (v_clamp >= V_THRESHOLD) begin
                v_next[j]   = V_RESET;             // Fire
                ref_next[j] = REFRACTORY_CYCLES;
                spk_next[j] = 1'b1;
            end else begin
                v_next[j]   = v_clamp;
                ref_next[j] = '0;
                spk_next[j] = 1'b0;
            end

            cnt_next = cnt_next + spike_count_t'(spk_next[j]);   // Popcount
        end
    end

    //----------------------------------------------------------------
    // State and output registers
    //----------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < NUM_RECURRENT; j++) begin
                v_mem[j]   <= V_REST;
                ref_cnt[j] <= '0;
            end
            output_spikes <= '0;
            spike_count   <= '0;
        end else if (enable) begin
            for (int j = 0; j < NUM_RECURRENT; j++) begin
                v_mem[j]   <= v_next[j];
                ref_cnt[j] <= ref_next[j];
            end
            output_spikes <= spk_next;   // Count lands on the same edge
            spike_count   <= cnt_next;
        end
    end

endmodule : lif_layer

`default_nettype wire

//--- activity_monitor.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// Activity monitor
// Turns the population spike count into the per-cycle alert, the
// windowed pain level, the lifetime total and the silence flag
//--------------------------------------------------------------------

module activity_monitor
    import spiker_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          enable,

    input  spike_count_t spike_count,

    output logic         alert,
    output stat_t        pain_level,
    output stat_t        total_spikes_lifetime,
    output logic         vacuum_state
);

    localparam logic [WINDOW_BITS-1:0] WINDOW_LAST = WINDOW_BITS'(WINDOW_CYCLES - 1);

    logic [WINDOW_BITS-1:0] window_cnt;    // Position inside the window
    stat_t                  window_sum;    // Running sum of this window
    stat_t                  prev_sum;      // Sum of the last full window
    stat_t                  count_ext;

    assign count_ext = stat_t'(spike_count);

    //----------------------------------------------------------------
    // Alert and lifetime total
    //----------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alert                 <= 1'b0;
            total_spikes_lifetime <= '0;
        end else if (enable) begin
            alert                 <= (spike_count >= ALERT_THRESHOLD);
            total_spikes_lifetime <= total_spikes_lifetime + count_ext;
        end
    end

    //----------------------------------------------------------------
    // Integration window
    //----------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_cnt <= '0;
            window_sum <= '0;
            prev_sum   <= '0;
            pain_level <= '0;
        end else if (enable) begin
            window_cnt <= window_cnt + 1'b1;   // Wraps at 256
            if (window_cnt == WINDOW_LAST) begin
                // Close the window, last cycle's count is not included
                pain_level <= window_sum;
                prev_sum   <= window_sum;
                window_sum <= '0;
            end else begin
                window_sum <= window_sum + count_ext;
            end
        end
    end

    // Silent when this window and the previous one saw no spikes
    assign vacuum_state = (window_sum == '0) && (prev_sum == '0);

endmodule : activity_monitor

`default_nettype wire

//--- vacuum_spiker.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// Silence-first anomaly detector, top level
// Synapse matrix into LIF layer into activity monitor, with a fixed
// three-cycle latency from input event to alert
//--------------------------------------------------------------------

module vacuum_spiker
    import spiker_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          enable,

    // Input event
    input  in_spikes_t   input_spikes,
    input  wire          input_valid,

    // Weight port
    input  wire          weight_we,
    input  syn_addr_t    weight_addr,
    input  weight_t      weight_wdata,
    output weight_t      weight_rdata,

    // Recurrent layer activity
    output out_spikes_t  output_spikes,
    output spike_count_t spike_count,

    // Monitor outputs
    output logic         alert,
    output stat_t        pain_level,
    output logic         vacuum_state,
    output stat_t        total_spikes_lifetime
);

    current_vec_t currents;        // Registered per-neuron currents
    logic         current_valid;   // One pulse per event

    synapse_matrix u_synapse_matrix (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .input_spikes  (input_spikes),
        .input_valid   (input_valid),
        .weight_we     (weight_we),
        .weight_addr   (weight_addr),
        .weight_wdata  (weight_wdata),
        .weight_rdata  (weight_rdata),
        .currents      (currents),
        .current_valid (current_valid)
    );

    lif_layer u_lif_layer (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .currents      (currents),
        .current_valid (current_valid),
        .output_spikes (output_spikes),
        .spike_count   (spike_count)
    );

    activity_monitor u_activity_monitor (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .enable                (enable),
        .spike_count           (spike_count),
        .alert                 (alert),
        .pain_level            (pain_level),
        .total_spikes_lifetime (total_spikes_lifetime),
        .vacuum_state          (vacuum_state)
    );

endmodule : vacuum_spiker

`default_nettype wire

//--- vacuum_spiker_checker.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// Assertion checker for the spiking core
// Reset values, alert rule and silence flag rule
//--------------------------------------------------------------------

module vacuum_spiker_checker
    import spiker_pkg::*;
(
    input wire          clk,
    input wire          rst_n,
    input wire          enable,
    input out_spikes_t  output_spikes,
    input spike_count_t spike_count,
    input wire          alert,
    input wire          vacuum_state,
    input stat_t        pain_level,
    input stat_t        total_spikes_lifetime
);

    logic [7:0] pos;    // Own copy of the window position
    stat_t      seen;   // Spikes counted in this window

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos  <= '0;
            seen <= '0;
        end else if (enable) begin
            pos  <= pos + 8'd1;
            seen <= (pos == 8'd255) ? '0 : seen + stat_t'(spike_count);
        end
    end

    // Alert follows the count one cycle later
    assert property (@(posedge clk) disable iff (!rst_n)
        enable |=> (alert == ($past(spike_count) >= ALERT_THRESHOLD)))
        else $error("alert rule violated");

    assert property (@(posedge clk) disable iff (!rst_n)
        vacuum_state |-> (seen == '0))
        else $error("vacuum high with spikes in the window");

    // Held in reset
    assert property (@(posedge clk) !rst_n |-> (!alert && output_spikes == '0 &&
        spike_count == '0 && pain_level == '0 && total_spikes_lifetime == '0))
        else $error("outputs not zero during reset");

endmodule : vacuum_spiker_checker

bind vacuum_spiker vacuum_spiker_checker chk0 (.*);

`default_nettype wire

//--- tb_vacuum_spiker.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// Testbench for the silence-first spiking core
// Table-driven stimulus against a cycle-accurate behavioral model
//--------------------------------------------------------------------

module tb_vacuum_spiker
    import spiker_pkg::*;
;
    logic clk = 1'b0;
    logic rst_n, enable, input_valid, weight_we;
    in_spikes_t input_spikes;
    syn_addr_t weight_addr;
    weight_t weight_wdata, weight_rdata;
    out_spikes_t output_spikes;
    spike_count_t spike_count;
    logic alert, vacuum_state;
    stat_t pain_level, total_spikes_lifetime;

    vacuum_spiker dut0 (.*);

    always #10 clk = ~clk;   // 20 ns period

    // Model state mirroring the registers of the core
    weight_t m_w [NUM_SYNAPSES];
    current_t m_cur [NUM_RECURRENT];
    current_t m_v [NUM_RECURRENT];
    int m_ref [NUM_RECURRENT];
    logic m_cv, m_alert;
    out_spikes_t m_spk;
    spike_count_t m_cnt;
    stat_t m_total, m_wsum, m_prev, m_pain;
    int m_wcnt;
    string cur_test;
    bit alert_seen;
    syn_addr_t wr_addr;   // Random write target
    weight_t wr_data;

    // Weight fill codes 0 default, 1 uniform value and 2 one neuron at 127
    string t_name [5] = '{"default_silence", "one_neuron_fire", "alert_group",
                          "random_mix", "quiet_tail"};
    int t_fill [5] = '{0, 2, 1, 1, 0};
    int t_val [5] = '{0, 0, 127, 100, 0};
    int t_neuron [5] = '{0, 3, 0, 0, 0};
    logic [15:0] t_pat [5] = '{16'hFFFF, 16'hFFFF, 16'hFFFF, 16'h0000, 16'h0000};
    bit t_rand [5] = '{0, 0, 0, 1, 0};
    int t_events [5] = '{40, 30, 12, 60, 0};
    int t_gap [5] = '{0, 0, 2, 1, 0};

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_weight(input string n, input weight_t exp, input weight_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s weight expected %0d actual %0d", n, exp, act));
    endtask

    task automatic check_spikes(input string n, input out_spikes_t exp, input out_spikes_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s spikes expected %h actual %h", n, exp, act));
    endtask

    task automatic check_count(input string n, input spike_count_t exp, input spike_count_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s count expected %0d actual %0d", n, exp, act));
    endtask

    task automatic check_stat(input string n, input stat_t exp, input stat_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s stat expected %0d actual %0d", n, exp, act));
    endtask

    task automatic check_flag(input string n, input logic exp, input logic act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s flag expected %b actual %b", n, exp, act));
    endtask

    // Advance the model by one clock edge with the inputs in force before it
    task automatic model_step();
        int vs;
        int acc;
        if (enable) begin
            m_alert = (m_cnt >= 5);
            m_total = m_total + stat_t'(m_cnt);
            if (m_wcnt == 255) begin
                m_pain = m_wsum;
                m_prev = m_wsum;
                m_wsum = 0;
            end else begin
                m_wsum = m_wsum + stat_t'(m_cnt);
            end
            m_wcnt = (m_wcnt + 1) % 256;
            m_cnt = 0;
            for (int j = 0; j < NUM_RECURRENT; j++) begin
                vs = int'(m_v[j]) - 128 + (m_cv ? int'(m_cur[j]) : 0);
                vs = (vs < 0) ? 0 : ((vs > 32767) ? 32767 : vs);   // Clamp
                m_spk[j] = 1'b0;
                if (m_ref[j] != 0) begin
                    m_ref[j] = m_ref[j] - 1;
                    m_v[j] = 0;
                end else if (vs >= 16384) begin
                    m_spk[j] = 1'b1;   // Fire and go refractory
                    m_v[j] = 0;
                    m_ref[j] = 5;
                    m_cnt = m_cnt + 1'b1;
                end else begin
                    m_v[j] = current_t'(vs);
                end
            end
            if (input_valid) begin
                for (int j = 0; j < NUM_RECURRENT; j++) begin
                    acc = 0;
                    for (int i = 0; i < NUM_INPUTS; i++)
                        if (input_spikes[i]) acc = acc + int'(m_w[i * 32 + j]);
                    m_cur[j] = current_t'(acc);
                end
            end
            m_cv = input_valid;
        end
        if (weight_we) m_w[weight_addr] = weight_wdata;   // Write lands after the sum
    endtask

    // Step the model and drive the inputs at the rising edge then compare at the falling edge
    task automatic drive(input logic en, input logic v, input in_spikes_t s,
                         input logic we, input syn_addr_t a, input weight_t d);
        @(posedge clk);
        model_step();
        enable <= en;
        input_valid <= v;
        input_spikes <= s;
        weight_we <= we;
        weight_addr <= a;
        weight_wdata <= d;
        @(negedge clk);
        check_weight(cur_test, m_w[weight_addr], weight_rdata);
        check_spikes(cur_test, m_spk, output_spikes);
        check_count(cur_test, m_cnt, spike_count);
        check_flag(cur_test, m_alert, alert);
        check_stat(cur_test, m_pain, pain_level);
        check_stat(cur_test, m_total, total_spikes_lifetime);
        check_flag(cur_test, (m_wsum == 0) && (m_prev == 0), vacuum_state);
        if (alert) alert_seen = 1'b1;
    endtask

    task automatic wait_window_end();
        int n;
        n = 0;
        drive(1'b1, 1'b0, '0, 1'b0, '0, '0);
        while (m_wcnt != 0) begin
            drive(1'b1, 1'b0, '0, 1'b0, '0, '0);
            n++;
            if (n > 300) abort_run("Window end never came within 300 cycles");
        end
    endtask

    task automatic apply_row(input int r);
        weight_t w;
        in_spikes_t pat;
        cur_test = t_name[r];
        for (int k = 0; k < NUM_SYNAPSES; k++) begin
            if (t_fill[r] == 0) w = W_INIT;
            else if (t_fill[r] == 1) w = weight_t'(t_val[r]);
            else w = ((k % 32) == t_neuron[r]) ? weight_t'(127) : W_INIT;
            drive(1'b1, 1'b0, '0, 1'b1, syn_addr_t'(k), w);
        end
        for (int e = 0; e < t_events[r]; e++) begin
            pat = t_rand[r] ? (in_spikes_t'($urandom) | 16'h0001) : t_pat[r];
            drive(1'b1, 1'b1, pat, 1'b0, '0, '0);
            repeat (t_gap[r]) drive(1'b1, 1'b0, '0, 1'b0, '0, '0);
        end
        repeat (8) drive(1'b1, 1'b0, '0, 1'b0, '0, '0);   // Drain the pipeline
    endtask

    initial begin
        void'($urandom(10));
        rst_n = 1'b1;
        {enable, input_valid, weight_we} = '0;
        input_spikes = '0;
        weight_addr = '0;
        weight_wdata = '0;
        for (int k = 0; k < NUM_SYNAPSES; k++) m_w[k] = W_INIT;
        for (int j = 0; j < NUM_RECURRENT; j++) begin
            m_cur[j] = 0;
            m_v[j] = V_REST;
            m_ref[j] = 0;
        end
        {m_cv, m_alert, m_spk, m_cnt, m_total, m_wsum, m_prev, m_pain} = '0;
        m_wcnt = 0;
        alert_seen = 1'b0;
        #2 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Weight port with untouched addresses first
        cur_test = "weight_port";
        for (int k = 0; k < 4; k++) begin
            drive(1'b1, 1'b0, '0, 1'b0, syn_addr_t'(k * 97), '0);
            check_weight(cur_test, weight_t'(-8), weight_rdata);
        end
        for (int k = 0; k < 20; k++) begin
            wr_addr = syn_addr_t'($urandom);
            wr_data = weight_t'($urandom);
            drive(1'b1, 1'b0, '0, 1'b1, wr_addr, wr_data);
            drive(1'b1, 1'b0, '0, 1'b0, wr_addr, '0);   // Read back one cycle later
            check_weight(cur_test, wr_data, weight_rdata);
        end
        for (int k = 0; k < 40; k++)
            drive(1'b1, 1'b0, '0, 1'b0, syn_addr_t'(k * 13), '0);

        for (int r = 0; r < 5; r++) begin
            apply_row(r);
            if (r == 0) begin
                wait_window_end();
                wait_window_end();
                check_flag(cur_test, 1'b1, vacuum_state);
                check_stat(cur_test, '0, pain_level);
            end
            if (r == 2 && !alert_seen) abort_run("Alert never rose with all neurons firing");
            if (r == 3) begin
                cur_test = "enable_hold";   // Events ignored and outputs held
                repeat (40) drive(1'b0, 1'b1, 16'hFFFF, 1'b0, '0, '0);
            end
        end

        // Two quiet windows bring the silence flag back
        cur_test = "quiet_windows";
        repeat (3) wait_window_end();
        check_flag(cur_test, 1'b1, vacuum_state);
        $display("All checks passed");
        $finish;
    end

endmodule : tb_vacuum_spiker

`default_nettype wire

//--- sources.f
spiker_pkg.sv
synapse_matrix.sv
lif_layer.sv
activity_monitor.sv
vacuum_spiker.sv
vacuum_spiker_checker.sv
tb_vacuum_spiker.sv

//--- run.sh
#!/bin/sh
# Build and run the spiking core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vacuum_spiker -f sources.f \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vtb_vacuum_spiker > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log || { echo "FAIL, run did not complete"; exit 1; }
echo "PASS"
exit 0
